// File: logic/pgu_pkg.sv
/*
 * Shared definitions for the page-descriptor unit.
 * Widths, the bus register map, bit positions inside the register
 * words and the types passed between the bus slave and the table store.
 * Modules import it inside their bodies; port lists use scoped names.
 */
package pgu_pkg;

    // ------------------------------
    // Widths and sizes
    localparam int PAGE_BITS  = 10;               // Page index width
    localparam int NUM_PAGES  = 1 << PAGE_BITS;   // 1024 descriptors
    localparam int FRAME_W    = 20;               // Frame number width
    localparam int WB_DATA_W  = 32;               // Bus data width
    localparam int REG_ADDR_W = 3;                // Register word address width

    typedef logic [PAGE_BITS-1:0]  page_idx_t;
    typedef logic [FRAME_W-1:0]    frame_t;
    typedef logic [WB_DATA_W-1:0]  wb_data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam page_idx_t LAST_PAGE = page_idx_t'(NUM_PAGES - 1);   // Fill stops here

    // ------------------------------
    // Register map, word offsets
    localparam reg_addr_t REG_INDEX  = 3'd0;   // Page index, read-write
    localparam reg_addr_t REG_MAP    = 3'd1;   // Frame number of indexed page
    localparam reg_addr_t REG_ACCESS = 3'd2;   // Invalid / read-only bits
    localparam reg_addr_t REG_REPRIO = 3'd3;   // Reprioritize bit
    localparam reg_addr_t REG_FILL   = 3'd4;   // Write starts bulk fill
    localparam reg_addr_t REG_STATUS = 3'd5;   // Busy and changed flags

    // Bit positions in ACCESS and STATUS words
    localparam int ACC_INV_BIT    = 1;
    localparam int ACC_RO_BIT     = 2;
    localparam int ST_BUSY_BIT    = 0;
    localparam int ST_CHANGED_BIT = 1;

    // Target of a table request
    typedef enum logic [2:0] {
        SEL_MAP,
        SEL_ACCESS,
        SEL_REPRIO,
        SEL_FILL,
        SEL_STATUS
    } table_sel_t;

    // Reprioritize fill sequencer states
    typedef enum logic {
        FILL_IDLE,
        FILL_RUN
    } fill_state_t;

endpackage

// File: logic/pgu_req_if.sv
/*
 * Request channel between the bus slave and the table store.
 * The slave pulses req with a target, an index and write data; the
 * store answers every req with exactly one done pulse, rdata valid
 * in that cycle. Only one request is outstanding at any time.
 */
`timescale 1ns/1ps

interface pgu_req_if;
    import pgu_pkg::*;

    logic       req;     // One-cycle request pulse
    logic       we;      // Write when high
    table_sel_t sel;     // Target table or register
    page_idx_t  index;   // Page addressed
    wb_data_t   wdata;   // Raw bus write word
    wb_data_t   rdata;   // Formatted as the register reads
    logic       done;    // One-cycle answer pulse

    modport table_master (
        output req, we, sel, index, wdata,
        input  rdata, done
    );

    modport table_store (
        input  req, we, sel, index, wdata,
        output rdata, done
    );

endinterface

// File: logic/pgu_reprio_fill.sv
/*
 * Bulk fill sequencer for the reprioritize bits.
 * A start pulse loads the counter with the start page; one page per
 * cycle is then offered for writing a one, up to the last page.
 * A start while running is ignored.
 */
`timescale 1ns/1ps

module pgu_reprio_fill (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_start,
    input  pgu_pkg::page_idx_t i_start_index,
    output logic               o_busy,
    output logic               o_wr_en,
    output pgu_pkg::page_idx_t o_wr_index
);
    import pgu_pkg::*;

    fill_state_t state_q;
    page_idx_t   cnt_q;       // Page being written

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= FILL_IDLE;
        end else begin
            case (state_q)
                FILL_IDLE: if (i_start)
                    state_q <= FILL_RUN;
                FILL_RUN:  if (cnt_q == LAST_PAGE)
                    state_q <= FILL_IDLE;             // Last page written
                default:   state_q <= FILL_IDLE;
            endcase
        end
    end

    // Counter loads on start, steps while running
    always_ff @(posedge clk) begin
        if (state_q == FILL_IDLE) begin
            if (i_start)
                cnt_q <= i_start_index;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign o_busy     = (state_q == FILL_RUN);
    assign o_wr_en    = (state_q == FILL_RUN);
    assign o_wr_index = cnt_q;

    // First write of a sweep lands on the start page
    a_start_load: assert property (@(posedge clk) disable iff (reset)
        (i_start && !o_busy) |=> (o_wr_en && o_wr_index == $past(i_start_index)));

    // No gap in the sweep before the last page
    a_wr_runs: assert property (@(posedge clk) disable iff (reset)
        (o_wr_en && o_wr_index != LAST_PAGE) |=> o_wr_en);

endmodule

// File: logic/pgu_page_tables.sv
/*
 * Table store of the page-descriptor unit.
 * Holds the frame map, the invalid/read-only pairs and the reprioritize
 * bits for every page, plus the sticky changed flag for the tracer.
 * Answers each request one cycle later; a reprioritize access that
 * meets a running fill waits until the fill is over.
 */
`timescale 1ns/1ps

module pgu_page_tables (
    input  logic           clk,
    input  logic           reset,
    pgu_req_if.table_store tbl
);
    import pgu_pkg::*;

    frame_t     map_mem    [NUM_PAGES];   // Frame numbers
    logic [1:0] acc_mem    [NUM_PAGES];   // {read-only, invalid}
    logic       reprio_mem [NUM_PAGES];   // Reprioritize requests

    logic       changed_q;    // Sticky, for tracer
    logic       pend_q;       // REPRIO request waiting for fill
    logic       done_q;
    wb_data_t   rdata_q;
    wb_data_t   rd_val;       // Formatted read word
    logic       held_now;
    logic       serve;
    logic       wr_map;
    logic       wr_acc;
    logic       wr_rep;
    logic       fill_start;
    logic       clr_changed;
    logic       fill_busy;
    logic       fill_wr_en;
    page_idx_t  fill_wr_index;

    // ------------------------------
    // Request service
    assign held_now = tbl.req & (tbl.sel == SEL_REPRIO) & fill_busy;
    assign serve    = (tbl.req & ~held_now) | (pend_q & ~fill_busy);

    // Held request uses the slave's fields, which stay put until done
    assign wr_map      = serve & tbl.we & (tbl.sel == SEL_MAP);
    assign wr_acc      = serve & tbl.we & (tbl.sel == SEL_ACCESS);
    assign wr_rep      = serve & tbl.we & (tbl.sel == SEL_REPRIO);
    assign fill_start  = serve & tbl.we & (tbl.sel == SEL_FILL);
    assign clr_changed = serve & tbl.we & (tbl.sel == SEL_STATUS) &
                         tbl.wdata[ST_CHANGED_BIT];

    always_comb begin
        rd_val = '0;
        case (tbl.sel)
            SEL_MAP:    rd_val = wb_data_t'(map_mem[tbl.index]);
            SEL_ACCESS: begin
                rd_val[ACC_INV_BIT] = acc_mem[tbl.index][0];
                rd_val[ACC_RO_BIT]  = acc_mem[tbl.index][1];
            end
            SEL_REPRIO: rd_val = wb_data_t'(reprio_mem[tbl.index]);
            SEL_STATUS: begin
                rd_val[ST_BUSY_BIT]    = fill_busy;
                rd_val[ST_CHANGED_BIT] = changed_q;
            end
            default:    rd_val = '0;                  // FILL reads zero
        endcase
    end

    // ------------------------------
    // Memories and read register
    always_ff @(posedge clk) begin
        if (wr_map)
            map_mem[tbl.index] <= tbl.wdata[FRAME_W-1:0];
        if (wr_acc)
            acc_mem[tbl.index] <= {tbl.wdata[ACC_RO_BIT], tbl.wdata[ACC_INV_BIT]};
        if (fill_wr_en)
            reprio_mem[fill_wr_index] <= 1'b1;        // Sequencer owns the port
        else if (wr_rep)
            reprio_mem[tbl.index] <= tbl.wdata[0];
        if (serve)
            rdata_q <= rd_val;
    end

    // ------------------------------
    // Control flags
    always_ff @(posedge clk) begin
        if (reset) begin
            done_q    <= 1'b0;
            pend_q    <= 1'b0;
            changed_q <= 1'b0;
        end else begin
            done_q <= serve;
            if (held_now)
                pend_q <= 1'b1;
            else if (pend_q && !fill_busy)
                pend_q <= 1'b0;                       // Served this edge
            if (clr_changed)
                changed_q <= 1'b0;
            if (wr_map || wr_acc || wr_rep || fill_wr_en)
                changed_q <= 1'b1;                    // Any update wins over clear
        end
    end

    assign tbl.done  = done_q;
    assign tbl.rdata = rdata_q;

    pgu_reprio_fill fill0 (
        .clk           (clk),
        .reset         (reset),
        .i_start       (fill_start),
        .i_start_index (tbl.index),
        .o_busy        (fill_busy),
        .o_wr_en       (fill_wr_en),
        .o_wr_index    (fill_wr_index)
    );

    // Reprioritize answers never overlap a running fill
    a_reprio_after_fill: assert property (@(posedge clk) disable iff (reset)
        (tbl.done && tbl.sel == SEL_REPRIO) |-> !fill_busy);

    // Slave keeps one request in flight
    a_no_req_pending: assert property (@(posedge clk) disable iff (reset)
        tbl.req |-> !pend_q);

endmodule

// File: logic/pgu_wb_slave.sv
/*
 * Wishbone classic slave of the page-descriptor unit.
 * Samples a strobe, captures address and data, then issues one table
 * request per transfer. The page index register and the reserved
 * offsets are served locally; ack follows the table or local done.
 */
`timescale 1ns/1ps

module pgu_wb_slave (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    input  logic               i_wb_we,
    input  pgu_pkg::reg_addr_t i_wb_adr,
    input  pgu_pkg::wb_data_t  i_wb_dat,
    output pgu_pkg::wb_data_t  o_wb_dat,
    output logic               o_wb_ack,
    pgu_req_if.table_master    tbl
);
    import pgu_pkg::*;

    logic       active_q;     // Strobe being served
    logic       sample_q;     // Strobe accepted on last edge
    logic       req_q;        // Table request pulse
    logic       loc_req_q;    // Local request pulse
    logic       loc_done_q;   // Local answer pulse
    reg_addr_t  adr_q;        // Captured word offset
    logic       we_q;
    wb_data_t   dat_q;
    page_idx_t  index_q;      // Page index register
    logic       start;
    logic       is_local;
    logic       done_any;
    table_sel_t sel;

    assign start    = i_wb_cyc & i_wb_stb & ~active_q;   // New transfer only
    assign is_local = (adr_q == REG_INDEX) || (adr_q > REG_STATUS);
    assign done_any = tbl.done | loc_done_q;

    // ------------------------------
    // Offset to table target
    always_comb begin
        case (adr_q)
            REG_MAP:    sel = SEL_MAP;
            REG_ACCESS: sel = SEL_ACCESS;
            REG_REPRIO: sel = SEL_REPRIO;
            REG_FILL:   sel = SEL_FILL;
            REG_STATUS: sel = SEL_STATUS;
            default:    sel = SEL_MAP;       // Local offsets, no table request
        endcase
    end

    // Request fields come from registered copies, stable for the whole transfer
    assign tbl.req   = req_q;
    assign tbl.we    = we_q;
    assign tbl.sel   = sel;
    assign tbl.index = index_q;
    assign tbl.wdata = dat_q;

    // ------------------------------
    // Transfer control
    always_ff @(posedge clk) begin
        if (reset) begin
            active_q   <= 1'b0;
            sample_q   <= 1'b0;
            req_q      <= 1'b0;
            loc_req_q  <= 1'b0;
            loc_done_q <= 1'b0;
            index_q    <= '0;
        end else begin
            sample_q   <= start;
            req_q      <= sample_q & ~is_local;    // Tables answer one edge later
            loc_req_q  <= sample_q & is_local;
            loc_done_q <= loc_req_q;               // Same latency as the tables
            if (start)
                active_q <= 1'b1;
            else if (done_any)
                active_q <= 1'b0;                  // Ready for next strobe
            if (loc_req_q && we_q && adr_q == REG_INDEX)
                index_q <= dat_q[PAGE_BITS-1:0];
        end
    end

    // Address and data capture
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= i_wb_adr;
            we_q  <= i_wb_we;
            dat_q <= i_wb_dat;
        end
    end

    // ------------------------------
    // Bus answer
    assign o_wb_ack = active_q & done_any;

    always_comb begin
        if (!is_local)
            o_wb_dat = tbl.rdata;                  // Already formatted by the store
        else if (adr_q == REG_INDEX)
            o_wb_dat = wb_data_t'(index_q);
        else
            o_wb_dat = '0;                         // Reserved offsets read zero
    end

    // Master holds the strobe until it sees ack
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb));

    // One ack per transfer, never back to back
    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        o_wb_ack |=> !o_wb_ack);

endmodule

// File: logic/pgu_top.sv
/*
 * Top level of the page-descriptor unit.
 * Plain Wishbone classic slave ports; the bus slave and the table
 * store talk over the request interface.
 */
`timescale 1ns/1ps

module pgu_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    input  logic               i_wb_we,
    input  pgu_pkg::reg_addr_t i_wb_adr,
    input  pgu_pkg::wb_data_t  i_wb_dat,
    output pgu_pkg::wb_data_t  o_wb_dat,
    output logic               o_wb_ack
);

    pgu_req_if tbl_if ();                 // Slave to table store

    pgu_wb_slave slave0 (
        .clk      (clk),
        .reset    (reset),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .tbl      (tbl_if.table_master)
    );

    pgu_page_tables tables0 (
        .clk   (clk),
        .reset (reset),
        .tbl   (tbl_if.table_store)
    );

endmodule

// File: dv/pgu_clkgen.sv
/*
 * Clock and reset source for the page-descriptor unit testbench.
 * 20 ns clock period; reset is held high for the first three rising
 * edges and released on the third edge.
 */
`timescale 1ns/1ps

module pgu_clkgen (
    output logic clk,
    output logic reset
);
    localparam int HALF_NS = 10;     // Half of the 20 ns period

    initial begin
        clk   = 1'b0;
        reset = 1'b1;                // Synchronous, active high
        repeat (3) @(posedge clk);
        reset <= 1'b0;               // Released on the third edge
    end

    always #HALF_NS clk = ~clk;

endmodule

// File: dv/pgu_tb.sv
/*
 * Testbench for the page-descriptor unit.
 * Wishbone read and write tasks drive the DUT. A model of the tables,
 * the index and the changed flag gives the expected value of every
 * read, and a compare process checks the queued results.
 */
`timescale 1ns/1ps

module pgu_tb;

    localparam int SEED       = 32'h2c57;
    localparam int MAX_CYCLES = 20000;   // ~900 transfers x 5 cycles + 3 fills, margin
    localparam int NPAGE      = 1024;
    localparam int LAST       = NPAGE - 1;

    // ------------------------------
    // Register map and bit positions
    localparam logic [2:0] R_INDEX  = 3'd0;
    localparam logic [2:0] R_MAP    = 3'd1;
    localparam logic [2:0] R_ACCESS = 3'd2;
    localparam logic [2:0] R_REPRIO = 3'd3;
    localparam logic [2:0] R_FILL   = 3'd4;
    localparam logic [2:0] R_STATUS = 3'd5;
    localparam logic [2:0] R_RSV6   = 3'd6;   // Reserved
    localparam logic [2:0] R_RSV7   = 3'd7;   // Reserved
    localparam int INV_BIT  = 1;
    localparam int RO_BIT   = 2;
    localparam int BUSY_BIT = 0;
    localparam int CHG_BIT  = 1;

    logic        clk;
    logic        reset;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [2:0]  i_wb_adr;
    logic [31:0] i_wb_dat;
    logic [31:0] o_wb_dat;
    logic        o_wb_ack;

    // Table model
    logic [19:0] map_m [NPAGE];     // Frame numbers
    logic [1:0]  acc_m [NPAGE];     // {read-only, invalid}
    logic        rep_m [NPAGE];     // Reprioritize bits
    logic        chg_m;             // Changed flag
    logic [9:0]  idx_m;             // Page index

    // Reads waiting for the compare process
    logic [2:0]  off_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    logic [2:0]  cmp_off;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;
    int          pages [$];         // Pages with a known frame
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    pgu_clkgen clkgen0 (.clk(clk), .reset(reset));

    pgu_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack)
    );

    // ------------------------------
    // Reference model
    function automatic logic [31:0] expected_read(input logic [2:0] offset);
        logic [31:0] v;
        v = '0;
        case (offset)
            R_INDEX:  v[9:0]  = idx_m;
            R_MAP:    v[19:0] = map_m[idx_m];     // Upper bits read zero
            R_ACCESS: begin
                v[INV_BIT] = acc_m[idx_m][0];
                v[RO_BIT]  = acc_m[idx_m][1];
            end
            R_REPRIO: v[0]       = rep_m[idx_m];
            R_STATUS: v[CHG_BIT] = chg_m;         // Busy expected low here
            default:  v = '0;                     // FILL and reserved
        endcase
        return v;
    endfunction

    task automatic update_model(input logic [2:0] offset, input logic [31:0] data);
        int p;
        case (offset)
            R_INDEX:  idx_m = data[9:0];
            R_MAP:    begin
                map_m[idx_m] = data[19:0];
                chg_m = 1'b1;
            end
            R_ACCESS: begin
                acc_m[idx_m] = {data[RO_BIT], data[INV_BIT]};
                chg_m = 1'b1;
            end
            R_REPRIO: begin
                rep_m[idx_m] = data[0];
                chg_m = 1'b1;
            end
            R_FILL:   begin
                for (p = int'(idx_m); p < NPAGE; p++)
                    rep_m[p] = 1'b1;              // Start page to last page
                chg_m = 1'b1;
            end
            R_STATUS: if (data[CHG_BIT]) chg_m = 1'b0;
            default:  ;                           // Reserved writes ignored
        endcase
    endtask

    // ------------------------------
    // Bus tasks
    task automatic bus_cycle(input logic we, input logic [2:0] offset,
                             input logic [31:0] data, output logic [31:0] rdata);
        @(posedge clk);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_adr <= offset;
        i_wb_dat <= data;
        @(negedge clk);
        while (!o_wb_ack)
            @(negedge clk);                       // Ack sampled mid-cycle
        rdata = o_wb_dat;
        @(posedge clk);
        i_wb_cyc <= 1'b0;                         // Strobe low for a cycle
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] offset, input logic [31:0] data);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, offset, data, unused_rd);
        update_model(offset, data);
    endtask

    task automatic wb_read(input logic [2:0] offset, output logic [31:0] rdata);
        bus_cycle(1'b0, offset, 32'h0, rdata);
    endtask

    task automatic check_read(input logic [2:0] offset);
        logic [31:0] exp_v;
        logic [31:0] act_v;
        exp_v = expected_read(offset);            // Model state before the read
        wb_read(offset, act_v);
        off_q.push_back(offset);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
    endtask

    task automatic set_index(input int page);
        wb_write(R_INDEX, 32'(page));
    endtask

    // Zero some pages, fill from start, check the sweep
    task automatic run_fill(input int start);
        int below [$];
        int above [$];
        logic [31:0] st;
        if (start > 0)
            repeat (3) below.push_back(int'($urandom_range(start - 1, 0)));
        repeat (3) above.push_back(int'($urandom_range(LAST, start)));
        above.push_back(LAST);                    // Far end cleared as well
        foreach (below[i]) begin
            set_index(below[i]);
            wb_write(R_REPRIO, 32'h0);
        end
        foreach (above[i]) begin
            set_index(above[i]);
            wb_write(R_REPRIO, 32'h0);
        end
        wb_write(R_STATUS, 32'h2);                // Clear changed first
        set_index(start);
        wb_write(R_FILL, $urandom);
        set_index(LAST);                          // Read at the far end waits for the fill
        check_read(R_REPRIO);
        st = 32'h1;
        while (st[BUSY_BIT])
            wb_read(R_STATUS, st);
        check_read(R_STATUS);
        foreach (below[i]) begin
            set_index(below[i]);
            check_read(R_REPRIO);
        end
        foreach (above[i]) begin
            set_index(above[i]);
            check_read(R_REPRIO);
        end
    endtask

    // ------------------------------
    // Compare and watchdog
    always @(posedge clk) begin
        while (act_q.size() > 0) begin
            cmp_off = off_q.pop_front();
            cmp_exp = exp_q.pop_front();
            cmp_act = act_q.pop_front();
            checks++;
            if (cmp_act !== cmp_exp) begin
                errors++;
                $display("Error: time %0t offset %0d expected %08h actual %08h",
                         $time, cmp_off, cmp_exp, cmp_act);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    initial begin
        int p;
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
        i_wb_adr <= 3'd0;
        i_wb_dat <= 32'h0;
        idx_m     = '0;
        chg_m     = 1'b0;
        void'($urandom(SEED));                    // One seed for the run
        @(negedge reset);

        check_read(R_STATUS);                     // Reset values
        check_read(R_INDEX);

        repeat (150) begin                        // Frame map
            p = int'($urandom_range(LAST, 0));
            pages.push_back(p);
            set_index(p);
            wb_write(R_MAP, $urandom);
        end
        repeat (30) begin                         // Overwrite some pages
            set_index(pages[$urandom_range(pages.size() - 1, 0)]);
            wb_write(R_MAP, $urandom);
        end
        foreach (pages[i]) begin
            set_index(pages[i]);
            check_read(R_MAP);
        end

        repeat (30) begin                         // Access and reprioritize bits
            set_index(int'($urandom_range(LAST, 0)));
            wb_write(R_ACCESS, $urandom);
            wb_write(R_REPRIO, $urandom);
            check_read(R_ACCESS);
            check_read(R_REPRIO);
        end

        wb_write(R_STATUS, 32'h2);                // Changed flag rules
        check_read(R_STATUS);
        set_index(int'($urandom_range(LAST, 0)));
        check_read(R_STATUS);
        check_read(R_INDEX);
        wb_write(R_MAP, $urandom);
        check_read(R_STATUS);
        wb_write(R_STATUS, $urandom & ~32'h2);
        check_read(R_STATUS);
        wb_write(R_STATUS, $urandom | 32'h2);
        check_read(R_STATUS);
        wb_write(R_ACCESS, $urandom);
        check_read(R_STATUS);
        wb_write(R_STATUS, 32'h2);
        wb_write(R_REPRIO, $urandom);
        check_read(R_STATUS);

        run_fill(int'($urandom_range(LAST - 1, 1)));
        run_fill(0);
        run_fill(LAST);

        set_index(pages[0]);                      // Reserved offsets
        wb_write(R_STATUS, 32'h2);
        wb_write(R_RSV6, $urandom);
        wb_write(R_RSV7, $urandom);
        check_read(R_RSV6);
        check_read(R_RSV7);
        check_read(R_MAP);
        check_read(R_STATUS);
        check_read(R_INDEX);

        repeat (2) @(negedge clk);                // Let the compare process drain
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: pgu_top.f
logic/pgu_pkg.sv
logic/pgu_req_if.sv
logic/pgu_reprio_fill.sv
logic/pgu_page_tables.sv
logic/pgu_wb_slave.sv
logic/pgu_top.sv
dv/pgu_clkgen.sv
dv/pgu_tb.sv

// File: Makefile
# Verilator flow for the page-descriptor unit
# Example: make sim VFLAGS="--timing --assert"

VERILATOR ?= verilator
TB_TOP    ?= pgu_tb
RTL_TOP   ?= pgu_top
FILELIST  ?= pgu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass line appears in the simulation output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
